//--- design/ppu_pkg.sv
package ppu_pkg;

  // ======================================
  // Display timing
  // ======================================
  localparam int DOTS_PER_LINE   = 456;
  localparam int LINES_PER_FRAME = 154;
  localparam int SCREEN_WIDTH    = 160;
  localparam int SCREEN_HEIGHT   = 144;
  // OAM scan, then pixel transfer, rest of line is hblank
  localparam int MODE2_LEN       = 80;
  localparam int MODE3_LEN       = 172;

  // ======================================
  // CPU address map
  // ======================================
  localparam logic [15:0] VRAM_START = 16'h8000;
  localparam logic [15:0] VRAM_END   = 16'h9FFF;
  localparam logic [15:0] OAM_START  = 16'hFE00;
  localparam logic [15:0] OAM_END    = 16'hFE9F;

  // LCD control registers
  localparam logic [15:0] LCDC_ADDR = 16'hFF40;
  localparam logic [15:0] STAT_ADDR = 16'hFF41;
  localparam logic [15:0] SCY_ADDR  = 16'hFF42;
  localparam logic [15:0] SCX_ADDR  = 16'hFF43;
  localparam logic [15:0] LY_ADDR   = 16'hFF44;
  localparam logic [15:0] LYC_ADDR  = 16'hFF45;
  localparam logic [15:0] BGP_ADDR  = 16'hFF47;
  localparam logic [15:0] WY_ADDR   = 16'hFF4A;
  localparam logic [15:0] WX_ADDR   = 16'hFF4B;

  // ======================================
  // Shared types
  // ======================================
  typedef enum logic [1:0] {
    MODE_HBLANK   = 2'd0,
    MODE_VBLANK   = 2'd1,
    MODE_OAM_SCAN = 2'd2,
    MODE_TRANSFER = 2'd3
  } ppu_mode_t;

  // One CPU access, strobes last a single cycle
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        write_en;
    logic        read_en;
  } cpu_bus_t;

  // Writable registers
  // stat_en bit 3 is LYC, then mode 2, mode 1, mode 0
  typedef struct packed {
    logic [7:0] lcdc;
    logic [3:0] stat_en;
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] lyc;
    logic [7:0] bgp;
    logic [7:0] wy;
    logic [7:0] wx;
  } ppu_regs_t;

  typedef struct packed {
    logic [7:0] ly;
    ppu_mode_t  mode;
    logic       lyc_match;
  } ppu_status_t;

  // Leftmost pixel sits in bit 7 of each plane
  typedef struct packed {
    logic [7:0] lo;
    logic [7:0] hi;
  } tile_row_t;

  typedef struct packed {
    logic [7:0] x;
    logic [7:0] y;
    logic [1:0] shade;
  } lcd_pixel_t;

endpackage

//--- design/ppu_dual_ram.sv
`timescale 1ns/1ps

module ppu_dual_ram #(
  parameter int DEPTH = 8192,
  localparam int AW = $clog2(DEPTH)
) (
  input  logic          clk,
  input  logic [AW-1:0] a_addr,
  input  logic [7:0]    a_wdata,
  input  logic          a_we,
  input  logic          a_re,
  output logic [7:0]    a_rdata,
  input  logic [AW-1:0] b_addr,
  input  logic          b_re,
  output logic [7:0]    b_rdata
);

  logic [7:0] mem [DEPTH];

  // Port A is the host side, read and write
  always_ff @(posedge clk) begin
    if (a_we) begin
      mem[a_addr] <= a_wdata;
    end
    if (a_re) begin
      a_rdata <= mem[a_addr];
    end
  end

  // Port B reads only, data holds until the next strobe
  always_ff @(posedge clk) begin
    if (b_re) begin
      b_rdata <= mem[b_addr];
    end
  end

endmodule

//--- design/ppu_row_fifo.sv
`timescale 1ns/1ps

module ppu_row_fifo #(
  parameter int DEPTH = 2,
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  localparam int CW = $clog2(DEPTH + 1)
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                flush,
  input  logic                push,
  input  ppu_pkg::tile_row_t  din,
  input  logic                pop,
  output ppu_pkg::tile_row_t  dout,
  output logic                full,
  output logic                empty
);

  ppu_pkg::tile_row_t mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;

  assign full  = (count == CW'(DEPTH));
  assign empty = (count == '0);
  assign dout  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push && !flush) begin
      mem[wr_ptr] <= din;
    end
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CW'(push) - CW'(pop);
    end
  end

  no_overflow_a: assert property (@(posedge clk) disable iff (reset)
    push && !flush |-> !full);
  no_underflow_a: assert property (@(posedge clk) disable iff (reset)
    pop && !flush |-> !empty);

endmodule

//--- design/ppu_fetcher.sv
`timescale 1ns/1ps

module ppu_fetcher #(
  parameter int VRAM_DEPTH = 8192,
  localparam int VAW = $clog2(VRAM_DEPTH)
) (
  input  logic                clk,
  input  logic                reset,
  input  ppu_pkg::ppu_regs_t  regs,
  input  logic [7:0]          ly,
  input  logic                line_start,
  input  logic [7:0]          vram_rdata,
  input  logic                full,
  output logic [VAW-1:0]      vram_addr,
  output logic                vram_re,
  output logic                push,
  output ppu_pkg::tile_row_t  row
);

  localparam logic [15:0] MAP_LO_BASE  = 16'h9800;
  localparam logic [15:0] MAP_HI_BASE  = 16'h9C00;
  localparam logic [15:0] DATA_U_BASE  = 16'h8000;
  localparam logic [15:0] DATA_S_BASE  = 16'h9000;
  localparam int          ROWS_PER_LINE = 20;

  typedef enum logic [1:0] {
    S_MAP  = 2'd0,
    S_LO   = 2'd1,
    S_HI   = 2'd2,
    S_PUSH = 2'd3
  } fetch_state_t;

  fetch_state_t state;
  logic        active;
  logic [4:0]  tile_cnt;
  logic [7:0]  idx_q;
  logic [7:0]  lo_q;
  logic [7:0]  bg_y;
  logic [4:0]  map_col;
  logic [7:0]  idx_sel;
  logic [15:0] map_addr;
  logic [15:0] tile_base;
  logic [15:0] data_addr;
  logic [15:0] fetch_addr;

  // ======================================
  // VRAM address generation
  // ======================================
  assign bg_y    = ly + regs.scy;
  // Coarse scroll only, map wraps at 32 tiles
  assign map_col = regs.scx[7:3] + tile_cnt;
  assign map_addr = (regs.lcdc[3] ? MAP_HI_BASE : MAP_LO_BASE)
                    + {6'd0, bg_y[7:3], map_col};

  // Index arrives from RAM in S_LO, held afterwards
  assign idx_sel = (state == S_LO) ? vram_rdata : idx_q;
  // lcdc bit 4 clear means signed index around 9000h
  assign tile_base = regs.lcdc[4] ? (DATA_U_BASE + {4'd0, idx_sel, 4'd0})
                                  : (DATA_S_BASE + {{4{idx_sel[7]}}, idx_sel, 4'd0});
  assign data_addr = tile_base + {12'd0, bg_y[2:0], state == S_HI};

  assign fetch_addr = (state == S_MAP) ? map_addr : data_addr;
  assign vram_addr  = VAW'(fetch_addr - ppu_pkg::VRAM_START);
  assign vram_re    = active && (state != S_PUSH);

  // High plane comes straight from RAM, it holds while stalled
  assign row.lo = lo_q;
  assign row.hi = vram_rdata;
  assign push   = active && (state == S_PUSH) && !full;

  // ======================================
  // Sequencer
  // ======================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= S_MAP;
      active   <= 1'b0;
      tile_cnt <= '0;
      idx_q    <= '0;
      lo_q     <= '0;
    end else if (line_start) begin
      state    <= S_MAP;
      active   <= 1'b1;
      tile_cnt <= '0;
    end else if (active) begin
      case (state)
        S_MAP: state <= S_LO;
        S_LO: begin
          idx_q <= vram_rdata;
          state <= S_HI;
        end
        S_HI: begin
          lo_q  <= vram_rdata;
          state <= S_PUSH;
        end
        default: begin
          // Wait here while the queue is full
          if (!full) begin
            state    <= S_MAP;
            tile_cnt <= tile_cnt + 5'd1;
            if (tile_cnt == ROWS_PER_LINE - 1) begin
              active <= 1'b0;
            end
          end
        end
      endcase
    end
  end

  // Stalled row stays put until the queue drains
  row_hold_a: assert property (@(posedge clk) disable iff (reset)
    active && (state == S_PUSH) && full |=> $stable(row));

endmodule

//--- design/ppu_host_port.sv
`timescale 1ns/1ps

module ppu_host_port #(
  parameter int VRAM_DEPTH = 8192,
  parameter int OAM_DEPTH  = 160,
  localparam int VAW = $clog2(VRAM_DEPTH),
  localparam int OAW = $clog2(OAM_DEPTH)
) (
  input  logic                  clk,
  input  logic                  reset,
  input  ppu_pkg::cpu_bus_t     cpu,
  input  ppu_pkg::ppu_status_t  status,
  input  logic [7:0]            vram_rdata,
  input  logic [7:0]            oam_rdata,
  output ppu_pkg::ppu_regs_t    regs,
  output logic [7:0]            cpu_rdata,
  output logic [VAW-1:0]        vram_addr,
  output logic [7:0]            vram_wdata,
  output logic                  vram_we,
  output logic                  vram_re,
  output logic [OAW-1:0]        oam_addr,
  output logic [7:0]            oam_wdata,
  output logic                  oam_we,
  output logic                  oam_re
);

  typedef enum logic [1:0] {
    SRC_REG  = 2'd0,
    SRC_VRAM = 2'd1,
    SRC_OAM  = 2'd2
  } rd_src_t;

  logic       sel_vram;
  logic       sel_oam;
  logic       vram_blocked;
  logic [7:0] reg_byte;
  logic [7:0] reg_q;
  rd_src_t    rd_src;

  // ======================================
  // Address decode
  // ======================================
  assign sel_vram = cpu.addr inside {[ppu_pkg::VRAM_START : ppu_pkg::VRAM_END]};
  assign sel_oam  = cpu.addr inside {[ppu_pkg::OAM_START : ppu_pkg::OAM_END]};
  // CPU loses VRAM while the fetcher owns it
  assign vram_blocked = (status.mode == ppu_pkg::MODE_TRANSFER);

  assign vram_addr  = VAW'(cpu.addr - ppu_pkg::VRAM_START);
  assign vram_wdata = cpu.wdata;
  assign vram_we    = cpu.write_en && sel_vram && !vram_blocked;
  assign vram_re    = cpu.read_en && sel_vram && !vram_blocked;

  // OAM stays open in every mode
  assign oam_addr  = OAW'(cpu.addr - ppu_pkg::OAM_START);
  assign oam_wdata = cpu.wdata;
  assign oam_we    = cpu.write_en && sel_oam;
  assign oam_re    = cpu.read_en && sel_oam;

  // ======================================
  // Register file
  // ======================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regs <= '0;
    end else if (cpu.write_en) begin
      case (cpu.addr)
        ppu_pkg::LCDC_ADDR: regs.lcdc    <= cpu.wdata;
        // Only the interrupt enables are writable
        ppu_pkg::STAT_ADDR: regs.stat_en <= cpu.wdata[6:3];
        ppu_pkg::SCY_ADDR:  regs.scy     <= cpu.wdata;
        ppu_pkg::SCX_ADDR:  regs.scx     <= cpu.wdata;
        ppu_pkg::LYC_ADDR:  regs.lyc     <= cpu.wdata;
        ppu_pkg::BGP_ADDR:  regs.bgp     <= cpu.wdata;
        ppu_pkg::WY_ADDR:   regs.wy      <= cpu.wdata;
        ppu_pkg::WX_ADDR:   regs.wx      <= cpu.wdata;
        // LY is read only
        default: ;
      endcase
    end
  end

  // ======================================
  // Read path
  // ======================================
  // Unmapped and blocked VRAM both fall to FFh
  always_comb begin
    case (cpu.addr)
      ppu_pkg::LCDC_ADDR: reg_byte = regs.lcdc;
      ppu_pkg::STAT_ADDR: reg_byte = {1'b1, regs.stat_en, status.lyc_match, status.mode};
      ppu_pkg::SCY_ADDR:  reg_byte = regs.scy;
      ppu_pkg::SCX_ADDR:  reg_byte = regs.scx;
      ppu_pkg::LY_ADDR:   reg_byte = status.ly;
      ppu_pkg::LYC_ADDR:  reg_byte = regs.lyc;
      ppu_pkg::BGP_ADDR:  reg_byte = regs.bgp;
      ppu_pkg::WY_ADDR:   reg_byte = regs.wy;
      ppu_pkg::WX_ADDR:   reg_byte = regs.wx;
      default:            reg_byte = 8'hFF;
    endcase
  end

  // Remember the source, RAM data lands a cycle later
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_src <= SRC_REG;
      reg_q  <= '0;
    end else if (cpu.read_en) begin
      reg_q <= reg_byte;
      if (sel_vram && !vram_blocked) begin
        rd_src <= SRC_VRAM;
      end else if (sel_oam) begin
        rd_src <= SRC_OAM;
      end else begin
        rd_src <= SRC_REG;
      end
    end
  end

  always_comb begin
    case (rd_src)
      SRC_VRAM: cpu_rdata = vram_rdata;
      SRC_OAM:  cpu_rdata = oam_rdata;
      default:  cpu_rdata = reg_q;
    endcase
  end

  one_strobe_a: assert property (@(posedge clk) disable iff (reset)
    !(cpu.write_en && cpu.read_en));

endmodule

//--- design/ppu_timing.sv
`timescale 1ns/1ps

module ppu_timing (
  input  logic                  clk,
  input  logic                  reset,
  input  ppu_pkg::ppu_regs_t    regs,
  input  ppu_pkg::tile_row_t    row,
  input  logic                  empty,
  output ppu_pkg::ppu_status_t  status,
  output logic                  line_start,
  output logic                  pop,
  output logic                  pixel_valid,
  output ppu_pkg::lcd_pixel_t   pixel,
  output logic                  vblank_req,
  output logic                  stat_req
);

  logic [8:0] dot;
  logic [7:0] ly;
  logic [7:0] ly_prev;
  logic       lyc_match;
  logic       lcd_on;
  logic       mode_irq_en;
  ppu_pkg::ppu_mode_t mode;
  ppu_pkg::ppu_mode_t mode_prev;

  // Background shifter
  logic [7:0] sh_lo;
  logic [7:0] sh_hi;
  logic [3:0] sh_cnt;
  logic [7:0] x_cnt;
  logic       in_transfer;
  logic       emit;
  logic [1:0] color;

  assign lcd_on = regs.lcdc[7];

  // ======================================
  // Dot and line counters
  // ======================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot <= '0;
      ly  <= '0;
    end else if (!lcd_on) begin
      // Held at the top left while the LCD is off
      dot <= '0;
      ly  <= '0;
    end else if (dot == ppu_pkg::DOTS_PER_LINE - 1) begin
      dot <= '0;
      if (ly == ppu_pkg::LINES_PER_FRAME - 1) begin
        ly <= '0;
      end else begin
        ly <= ly + 8'd1;
      end
    end else begin
      dot <= dot + 9'd1;
    end
  end

  always_comb begin
    if (ly >= ppu_pkg::SCREEN_HEIGHT) begin
      mode = ppu_pkg::MODE_VBLANK;
    end else if (dot < ppu_pkg::MODE2_LEN) begin
      mode = ppu_pkg::MODE_OAM_SCAN;
    end else if (dot < ppu_pkg::MODE2_LEN + ppu_pkg::MODE3_LEN) begin
      mode = ppu_pkg::MODE_TRANSFER;
    end else begin
      mode = ppu_pkg::MODE_HBLANK;
    end
  end

  assign status.ly        = ly;
  assign status.mode      = mode;
  assign status.lyc_match = lyc_match;

  // First dot of mode 3, visible lines only
  assign line_start = (mode == ppu_pkg::MODE_TRANSFER) && (dot == ppu_pkg::MODE2_LEN);

  // ======================================
  // Interrupt pulses
  // ======================================
  always_comb begin
    case (mode)
      ppu_pkg::MODE_HBLANK:   mode_irq_en = regs.stat_en[0];
      ppu_pkg::MODE_VBLANK:   mode_irq_en = regs.stat_en[1];
      ppu_pkg::MODE_OAM_SCAN: mode_irq_en = regs.stat_en[2];
      default:                mode_irq_en = 1'b0;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ly_prev    <= '0;
      mode_prev  <= ppu_pkg::MODE_HBLANK;
      lyc_match  <= 1'b0;
      vblank_req <= 1'b0;
      stat_req   <= 1'b0;
    end else begin
      ly_prev   <= ly;
      mode_prev <= mode;
      lyc_match <= lcd_on && (ly == regs.lyc);
      // Last dot of the last visible line
      vblank_req <= lcd_on && (dot == ppu_pkg::DOTS_PER_LINE - 1)
                    && (ly == ppu_pkg::SCREEN_HEIGHT - 1);
      // LYC hit wins, else entry into an enabled mode
      stat_req <= (regs.stat_en[3] && (ly != ly_prev) && (ly == regs.lyc))
                  || ((mode != mode_prev) && mode_irq_en);
    end
  end

  // ======================================
  // Pixel shifter and palette
  // ======================================
  assign in_transfer = (mode == ppu_pkg::MODE_TRANSFER);
  assign emit  = in_transfer && !line_start && (sh_cnt != 4'd0)
                 && (x_cnt < ppu_pkg::SCREEN_WIDTH);
  // Refill when drained, or as the last held pixel leaves
  assign pop   = in_transfer && !line_start && !empty
                 && ((sh_cnt == 4'd0) || ((sh_cnt == 4'd1) && emit));
  assign color = {sh_hi[7], sh_lo[7]};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sh_lo       <= '0;
      sh_hi       <= '0;
      sh_cnt      <= '0;
      x_cnt       <= '0;
      pixel_valid <= 1'b0;
      pixel       <= '0;
    end else begin
      pixel_valid <= emit;
      if (emit) begin
        pixel.x     <= x_cnt;
        pixel.y     <= ly;
        pixel.shade <= regs.bgp[{color, 1'b0} +: 2];
        x_cnt       <= x_cnt + 8'd1;
      end
      if (line_start) begin
        sh_cnt <= '0;
        x_cnt  <= '0;
      end else if (pop) begin
        sh_lo  <= row.lo;
        sh_hi  <= row.hi;
        sh_cnt <= 4'd8;
      end else if (emit) begin
        sh_lo  <= {sh_lo[6:0], 1'b0};
        sh_hi  <= {sh_hi[6:0], 1'b0};
        sh_cnt <= sh_cnt - 4'd1;
      end
    end
  end

  // Pixels only leave while the LCD sits in mode 3
  pix_in_transfer_a: assert property (@(posedge clk) disable iff (reset)
    pixel_valid && regs.lcdc[7] |-> status.mode == ppu_pkg::MODE_TRANSFER);

  // Whole line out by the time mode 3 ends
  line_complete_a: assert property (@(posedge clk) disable iff (reset)
    (mode_prev == ppu_pkg::MODE_TRANSFER) && (mode == ppu_pkg::MODE_HBLANK)
    |-> x_cnt == ppu_pkg::SCREEN_WIDTH);

endmodule

//--- design/ppu_top.sv
`timescale 1ns/1ps

module ppu_top #(
  parameter int ROW_FIFO_DEPTH = 2,
  parameter int VRAM_DEPTH     = 8192,
  parameter int OAM_DEPTH      = 160
) (
  input  logic                 clk,
  input  logic                 reset,
  input  ppu_pkg::cpu_bus_t    cpu,
  output logic [7:0]           cpu_rdata,
  output logic                 pixel_valid,
  output ppu_pkg::lcd_pixel_t  pixel,
  output logic                 vblank_req,
  output logic                 stat_req
);

  localparam int VAW = $clog2(VRAM_DEPTH);
  localparam int OAW = $clog2(OAM_DEPTH);

  ppu_pkg::ppu_regs_t   regs;
  ppu_pkg::ppu_status_t status;

  // Row queue between fetcher and shifter
  ppu_pkg::tile_row_t fetch_row;
  ppu_pkg::tile_row_t fifo_row;
  logic line_start;
  logic push;
  logic pop;
  logic full;
  logic empty;

  // VRAM host side and fetch side
  logic [VAW-1:0] vram_a_addr;
  logic [7:0]     vram_a_wdata;
  logic           vram_a_we;
  logic           vram_a_re;
  logic [7:0]     vram_a_rdata;
  logic [VAW-1:0] vram_b_addr;
  logic           vram_b_re;
  logic [7:0]     vram_b_rdata;

  // OAM host side
  logic [OAW-1:0] oam_addr;
  logic [7:0]     oam_wdata;
  logic           oam_we;
  logic           oam_re;
  logic [7:0]     oam_rdata;

  // ======================================
  // Control
  // ======================================
  ppu_host_port #(
    .VRAM_DEPTH (VRAM_DEPTH),
    .OAM_DEPTH  (OAM_DEPTH)
  ) host_i (
    .clk        (clk),
    .reset      (reset),
    .cpu        (cpu),
    .status     (status),
    .vram_rdata (vram_a_rdata),
    .oam_rdata  (oam_rdata),
    .regs       (regs),
    .cpu_rdata  (cpu_rdata),
    .vram_addr  (vram_a_addr),
    .vram_wdata (vram_a_wdata),
    .vram_we    (vram_a_we),
    .vram_re    (vram_a_re),
    .oam_addr   (oam_addr),
    .oam_wdata  (oam_wdata),
    .oam_we     (oam_we),
    .oam_re     (oam_re)
  );

  ppu_timing timing_i (
    .clk         (clk),
    .reset       (reset),
    .regs        (regs),
    .row         (fifo_row),
    .empty       (empty),
    .status      (status),
    .line_start  (line_start),
    .pop         (pop),
    .pixel_valid (pixel_valid),
    .pixel       (pixel),
    .vblank_req  (vblank_req),
    .stat_req    (stat_req)
  );

  // ======================================
  // Background path
  // ======================================
  ppu_fetcher #(
    .VRAM_DEPTH (VRAM_DEPTH)
  ) fetch_i (
    .clk        (clk),
    .reset      (reset),
    .regs       (regs),
    .ly         (status.ly),
    .line_start (line_start),
    .vram_rdata (vram_b_rdata),
    .full       (full),
    .vram_addr  (vram_b_addr),
    .vram_re    (vram_b_re),
    .push       (push),
    .row        (fetch_row)
  );

  // Emptied at the start of every visible line
  ppu_row_fifo #(
    .DEPTH (ROW_FIFO_DEPTH)
  ) fifo_i (
    .clk   (clk),
    .reset (reset),
    .flush (line_start),
    .push  (push),
    .din   (fetch_row),
    .pop   (pop),
    .dout  (fifo_row),
    .full  (full),
    .empty (empty)
  );

  // ======================================
  // Memories
  // ======================================
  ppu_dual_ram #(
    .DEPTH (VRAM_DEPTH)
  ) vram_i (
    .clk     (clk),
    .a_addr  (vram_a_addr),
    .a_wdata (vram_a_wdata),
    .a_we    (vram_a_we),
    .a_re    (vram_a_re),
    .a_rdata (vram_a_rdata),
    .b_addr  (vram_b_addr),
    .b_re    (vram_b_re),
    .b_rdata (vram_b_rdata)
  );

  // No sprite engine, second port stays idle
  ppu_dual_ram #(
    .DEPTH (OAM_DEPTH)
  ) oam_i (
    .clk     (clk),
    .a_addr  (oam_addr),
    .a_wdata (oam_wdata),
    .a_we    (oam_we),
    .a_re    (oam_re),
    .a_rdata (oam_rdata),
    .b_addr  ('0),
    .b_re    (1'b0),
    .b_rdata ()
  );

endmodule

//--- test/ppu_tb.sv
`timescale 1ns/1ps

module ppu_tb;

  // ======================================
  // Run limits
  // ======================================
  localparam int FRAME_CYCLES = ppu_pkg::DOTS_PER_LINE * ppu_pkg::LINES_PER_FRAME;
  // Interrupt tests take a little over three frames
  // VRAM loading and rendering add about 24,000 cycles
  localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES + 10000;
  localparam int RENDER_LINES = 8;

  logic                clk;
  logic                reset;
  ppu_pkg::cpu_bus_t   cpu;
  logic [7:0]          cpu_rdata;
  logic                pixel_valid;
  ppu_pkg::lcd_pixel_t pixel;
  logic                vblank_req;
  logic                stat_req;

  integer seed;
  int     errors;
  int     pixels_checked;
  int     cycle_count = 0;

  // Model of VRAM contents, offset from 8000h
  logic [7:0] vram_model [8192];
  // Register values the render model works from
  logic [7:0] cur_lcdc;
  logic [7:0] cur_scy;
  logic [7:0] cur_scx;
  logic [7:0] cur_bgp;

  ppu_top dut_i (
    .clk         (clk),
    .reset       (reset),
    .cpu         (cpu),
    .cpu_rdata   (cpu_rdata),
    .pixel_valid (pixel_valid),
    .pixel       (pixel),
    .vblank_req  (vblank_req),
    .stat_req    (stat_req)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timed out: the run went past %0d cycles without finishing", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // ======================================
  // Helpers
  // ======================================
  task automatic log_fail(input string msg);
    $display("Fail at %0d ns: %s", $time, msg);
    errors++;
  endtask

  function automatic logic [7:0] rand_byte();
    return 8'($random(seed));
  endfunction

  // Single-cycle write strobe, set up on the falling edge
  task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
    @(negedge clk);
    cpu.addr     = addr;
    cpu.wdata    = data;
    cpu.write_en = 1'b1;
    cpu.read_en  = 1'b0;
    @(negedge clk);
    cpu.write_en = 1'b0;
  endtask

  // Read data is registered, sampled one edge after the strobe
  task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
    @(negedge clk);
    cpu.addr     = addr;
    cpu.read_en  = 1'b1;
    cpu.write_en = 1'b0;
    @(negedge clk);
    cpu.read_en = 1'b0;
    data = cpu_rdata;
  endtask

  task automatic vram_load(input logic [15:0] addr, input logic [7:0] data);
    cpu_write(addr, data);
    vram_model[int'(addr) - 'h8000] = data;
  endtask

  // Returns the cycle count of the next vblank or STAT pulse
  task automatic wait_irq(input bit use_stat, output int at);
    @(negedge clk);
    while ((use_stat ? stat_req : vblank_req) !== 1'b1) begin
      @(negedge clk);
    end
    at = cycle_count;
  endtask

  // Shade of one background pixel, from the VRAM model
  function automatic logic [1:0] expected_shade(input int x, input int y);
    int bg_y;
    int map_addr;
    int idx;
    int data_addr;
    int bitn;
    logic [7:0] lo;
    logic [7:0] hi;
    logic [1:0] color;
    bg_y = (y + cur_scy) % 256;
    map_addr = (cur_lcdc[3] ? 'h9C00 : 'h9800) + (bg_y / 8) * 32
               + ((cur_scx / 8 + x / 8) % 32);
    idx = vram_model[map_addr - 'h8000];
    if (cur_lcdc[4]) begin
      data_addr = 'h8000 + idx * 16;
    end else begin
      // Signed index around 9000h
      data_addr = 'h9000 + ((idx >= 128) ? idx - 256 : idx) * 16;
    end
    data_addr = data_addr + (bg_y % 8) * 2;
    lo = vram_model[data_addr - 'h8000];
    hi = vram_model[data_addr + 1 - 'h8000];
    bitn = 7 - (x % 8);
    color = {hi[bitn], lo[bitn]};
    return cur_bgp[2 * color +: 2];
  endfunction

  task automatic check_reg_rw(input logic [15:0] addr);
    logic [7:0] val;
    logic [7:0] got;
    val = rand_byte();
    cpu_write(addr, val);
    cpu_read(addr, got);
    if (got !== val) begin
      log_fail($sformatf("register %h read %h, wrote %h", addr, got, val));
    end
  endtask

  // ======================================
  // Directed tests
  // ======================================
  task automatic test_reset_state();
    logic [7:0] got;
    if (pixel_valid !== 1'b0 || vblank_req !== 1'b0 || stat_req !== 1'b0) begin
      log_fail("pixel_valid, vblank_req or stat_req high after reset");
    end
    cpu_read(ppu_pkg::LY_ADDR, got);
    if (got !== 8'h00) log_fail($sformatf("LY after reset %h, expected 00", got));
    cpu_read(ppu_pkg::STAT_ADDR, got);
    if (got !== 8'h82) log_fail($sformatf("STAT after reset %h, expected 82", got));
    cpu_read(ppu_pkg::LCDC_ADDR, got);
    if (got !== 8'h00) log_fail($sformatf("LCDC after reset %h, expected 00", got));
    // Hole in the register block
    cpu_read(16'hFF4C, got);
    if (got !== 8'hFF) log_fail($sformatf("unmapped FF4C read %h, expected FF", got));
  endtask

  task automatic test_registers();
    logic [7:0] val;
    logic [7:0] got;
    check_reg_rw(ppu_pkg::SCY_ADDR);
    check_reg_rw(ppu_pkg::SCX_ADDR);
    check_reg_rw(ppu_pkg::LYC_ADDR);
    check_reg_rw(ppu_pkg::BGP_ADDR);
    check_reg_rw(ppu_pkg::WY_ADDR);
    check_reg_rw(ppu_pkg::WX_ADDR);
    // LY is read only, LCD is off so it stays 0
    cpu_write(ppu_pkg::LY_ADDR, 8'h5A);
    cpu_read(ppu_pkg::LY_ADDR, got);
    if (got !== 8'h00) log_fail($sformatf("LY took a write, reads %h", got));
    // Only bits 6..3 stick, mode 2 and no coincidence with LCD off
    val = rand_byte();
    cpu_write(ppu_pkg::STAT_ADDR, val);
    cpu_read(ppu_pkg::STAT_ADDR, got);
    if (got !== (8'h82 | (val & 8'h78))) begin
      log_fail($sformatf("STAT read %h after writing %h", got, val));
    end
    cpu_write(ppu_pkg::STAT_ADDR, 8'h00);
  endtask

  task automatic test_memory_access();
    logic [15:0] vaddr [4];
    logic [7:0]  vdata [4];
    logic [15:0] oaddr [4];
    logic [7:0]  odata [4];
    logic [7:0]  got;
    logic [7:0]  stat;
    vaddr[0] = 16'h8000;
    vaddr[1] = 16'h9FFF;
    vaddr[2] = 16'h8000 + ({rand_byte(), rand_byte()} & 16'h1FFF);
    vaddr[3] = 16'h8000 + ({rand_byte(), rand_byte()} & 16'h1FFF);
    oaddr[0] = 16'hFE00;
    oaddr[1] = 16'hFE9F;
    oaddr[2] = 16'hFE00 + 16'(rand_byte() % 160);
    oaddr[3] = 16'hFE00 + 16'(rand_byte() % 160);
    for (int i = 0; i < 4; i++) begin
      vdata[i] = rand_byte();
      odata[i] = rand_byte();
      cpu_write(vaddr[i], vdata[i]);
      cpu_write(oaddr[i], odata[i]);
    end
    // A random address may repeat, so check against the last write
    for (int i = 0; i < 4; i++) begin
      for (int j = i + 1; j < 4; j++) begin
        if (vaddr[j] == vaddr[i]) vdata[i] = vdata[j];
        if (oaddr[j] == oaddr[i]) odata[i] = odata[j];
      end
    end
    for (int i = 0; i < 4; i++) begin
      cpu_read(vaddr[i], got);
      if (got !== vdata[i]) begin
        log_fail($sformatf("VRAM %h read %h, wrote %h", vaddr[i], got, vdata[i]));
      end
      cpu_read(oaddr[i], got);
      if (got !== odata[i]) begin
        log_fail($sformatf("OAM %h read %h, wrote %h", oaddr[i], got, odata[i]));
      end
    end

    // LCD on, catch the start of pixel transfer
    cpu_write(ppu_pkg::LCDC_ADDR, 8'h80);
    cpu_read(ppu_pkg::STAT_ADDR, stat);
    while (stat[1:0] != 2'd3) begin
      cpu_read(ppu_pkg::STAT_ADDR, stat);
    end
    cpu_read(vaddr[0], got);
    if (got !== 8'hFF) log_fail($sformatf("VRAM read in mode 3 gave %h, expected FF", got));
    cpu_write(vaddr[0], ~vdata[0]);
    odata[1] = rand_byte();
    cpu_write(oaddr[1], odata[1]);
    cpu_read(oaddr[1], got);
    if (got !== odata[1]) begin
      log_fail($sformatf("OAM read in mode 3 gave %h, wrote %h", got, odata[1]));
    end
    cpu_read(ppu_pkg::STAT_ADDR, stat);
    if (stat[1:0] != 2'd3) begin
      log_fail("mode 3 ended before the blocked accesses finished");
    end

    // Blocked write must not have landed
    cpu_write(ppu_pkg::LCDC_ADDR, 8'h00);
    cpu_read(vaddr[0], got);
    if (got !== vdata[0]) log_fail($sformatf("blocked VRAM write landed, read %h", got));
  endtask

  task automatic test_frame_timing();
    int t0;
    int t1;
    cpu_write(ppu_pkg::LCDC_ADDR, 8'h80);
    wait_irq(1'b0, t0);
    @(negedge clk);
    if (vblank_req !== 1'b0) log_fail("vblank_req longer than one cycle");
    wait_irq(1'b0, t1);
    if (t1 - t0 != FRAME_CYCLES) begin
      log_fail($sformatf("vblank interval %0d cycles, expected %0d", t1 - t0, FRAME_CYCLES));
    end
  endtask

  task automatic test_lyc_interrupt();
    int t0;
    int t1;
    logic [7:0] got;
    // LYC first, so no match fires on a stale compare value
    cpu_write(ppu_pkg::LYC_ADDR, 8'd40);
    cpu_write(ppu_pkg::STAT_ADDR, 8'h40);
    wait_irq(1'b1, t0);
    cpu_read(ppu_pkg::LY_ADDR, got);
    if (got !== 8'd40) log_fail($sformatf("LY after STAT pulse %0d, expected 40", got));
    wait_irq(1'b1, t1);
    if (t1 - t0 != FRAME_CYCLES) begin
      log_fail($sformatf("LYC pulse interval %0d cycles, expected %0d", t1 - t0, FRAME_CYCLES));
    end
    cpu_read(ppu_pkg::LY_ADDR, got);
    if (got !== 8'd40) log_fail($sformatf("LY after second STAT pulse %0d", got));
    cpu_write(ppu_pkg::STAT_ADDR, 8'h00);
    cpu_write(ppu_pkg::LCDC_ADDR, 8'h00);
  endtask

  // Lines from the top of the frame, x and y counted here
  task automatic check_lines(input int n);
    int got;
    logic [1:0] exp;
    for (int line = 0; line < n; line++) begin
      got = 0;
      while (got < ppu_pkg::SCREEN_WIDTH) begin
        @(negedge clk);
        if (pixel_valid) begin
          exp = expected_shade(got, line);
          if (pixel.x !== got || pixel.y !== line) begin
            log_fail($sformatf("pixel at (%0d,%0d), expected (%0d,%0d)",
                               pixel.x, pixel.y, got, line));
          end else if (pixel.shade !== exp) begin
            log_fail($sformatf("shade at (%0d,%0d) is %0d, expected %0d",
                               got, line, pixel.shade, exp));
          end
          pixels_checked++;
          got++;
        end
      end
    end
  endtask

  task automatic render_pass(input logic [7:0] lcdc_val);
    logic [15:0] map_base;
    cpu_write(ppu_pkg::LCDC_ADDR, 8'h00);
    map_base = lcdc_val[3] ? 16'h9C00 : 16'h9800;
    for (int i = 0; i < 1024; i++) begin
      vram_load(map_base + 16'(i), rand_byte());
    end
    cur_scy  = rand_byte();
    cur_scx  = rand_byte() & 8'hF8;
    cur_bgp  = rand_byte();
    cur_lcdc = lcdc_val;
    cpu_write(ppu_pkg::SCY_ADDR, cur_scy);
    cpu_write(ppu_pkg::SCX_ADDR, cur_scx);
    cpu_write(ppu_pkg::BGP_ADDR, cur_bgp);
    cpu_write(ppu_pkg::LCDC_ADDR, cur_lcdc);
    check_lines(RENDER_LINES);
  endtask

  task automatic test_background();
    // Tile data for both addressing modes, 8000h..97FFh
    cpu_write(ppu_pkg::LCDC_ADDR, 8'h00);
    for (int a = 'h8000; a < 'h9800; a++) begin
      vram_load(16'(a), rand_byte());
    end
    // Unsigned tiles with map 9800h, then signed tiles with map 9C00h
    render_pass(8'h91);
    render_pass(8'h89);
    cpu_write(ppu_pkg::LCDC_ADDR, 8'h00);
  endtask

  // ======================================
  // Main sequence
  // ======================================
  initial begin
    seed           = 32'h939f_800e;
    errors         = 0;
    pixels_checked = 0;
    cur_lcdc       = '0;
    cur_scy        = '0;
    cur_scx        = '0;
    cur_bgp        = '0;
    cpu            = '0;
    reset          = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    test_reset_state();
    test_registers();
    test_memory_access();
    test_frame_timing();
    test_lyc_interrupt();
    test_background();

    $display("Summary: %0d errors, %0d pixels checked, %0d cycles",
             errors, pixels_checked, cycle_count);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- project.f
design/ppu_pkg.sv
design/ppu_dual_ram.sv
design/ppu_row_fifo.sv
design/ppu_fetcher.sv
design/ppu_host_port.sv
design/ppu_timing.sv
design/ppu_top.sv
test/ppu_tb.sv

//--- Bender.yml
package:
  name: ppu_bg

sources:
  - files:
      - design/ppu_pkg.sv
      - design/ppu_dual_ram.sv
      - design/ppu_row_fifo.sv
      - design/ppu_fetcher.sv
      - design/ppu_host_port.sv
      - design/ppu_timing.sv
      - design/ppu_top.sv
  - target: test
    files:
      - test/ppu_tb.sv
